//--- leading_one_detect.sv
// Priority encoder for the raw fraction sum
// Gives how far the highest set bit lies below the carry position
`timescale 1ns/1ps
`default_nettype none

module leading_one_detect (
    input  posit_pkg::sum_t    in,
    output posit_pkg::lod_pos_t pos
);

    import posit_pkg::*;

    always_comb
    begin
        // Saturates for a leading one at bit 1 or lower, or no bit at all
        pos = lod_pos_t'(31);
        for (int i = 1; i <= ABITS; i++)
        begin
            if (in[i])
                pos = lod_pos_t'(ABITS - i);    // Highest bit wins
        end
    end

endmodule

`default_nettype wire

//--- posit_add_checker.sv
// Testbench scoreboard for the posit adder
// Queues the expected sum at each start and compares it with the DUT outputs at done
`timescale 1ns/1ps
`default_nettype none

module posit_add_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  posit_pkg::posit_t  exp_result,
    input  logic               exp_inf,
    input  logic               exp_zero,
    input  logic [159:0]       exp_name,
    input  posit_pkg::posit_t  result,
    input  logic               inf,
    input  logic               zero,
    input  logic               done,
    output int                 pending,
    output int                 passed,
    output int                 failed,
    output int                 errors
);

    import posit_pkg::*;

    localparam int LATENCY = 8;    // Start edge to done edge

    posit_t       q_result[$];
    logic         q_inf[$];
    logic         q_zero[$];
    logic [159:0] q_name[$];
    int           q_cycle[$];
    int           cycle;

    initial
    begin
        pending = 0;
        passed  = 0;
        failed  = 0;
        errors  = 0;
        cycle   = 0;
    end

    // One [FAIL] line per wrong field
    task automatic compare_field(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual, input logic [159:0] name,
                                 inout int count);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t test %0s: %0s expected 0x%08h got 0x%08h",
                     $time, name, sig, expected, actual);
            count = count + 1;
        end
    endtask

    // Called once the stimulus has drained
    task report_leftovers;
        if (q_result.size() != 0)
        begin
            $display("At %0t, %0d expected results never came out of the DUT",
                     $time, q_result.size());
            errors = errors + q_result.size();
        end
    endtask

    always @(posedge clk)
    begin : watch
        posit_t       e_result;
        logic         e_inf;
        logic         e_zero;
        logic [159:0] e_name;
        int           e_cycle;
        int           test_errors;

        cycle = cycle + 1;
        if (!rst_n)
        begin
            if (done !== 1'b0)
            begin
                $display("At %0t, done is not low while reset is asserted", $time);
                errors = errors + 1;
            end
        end
        else
        begin
            if (done === 1'b1)
            begin
                if (q_result.size() == 0)
                begin
                    $display("At %0t, done arrived with no operation outstanding", $time);
                    errors = errors + 1;
                end
                else
                begin
                    e_result    = q_result.pop_front();
                    e_inf       = q_inf.pop_front();
                    e_zero      = q_zero.pop_front();
                    e_name      = q_name.pop_front();
                    e_cycle     = q_cycle.pop_front();
                    test_errors = 0;
                    compare_field("done latency", LATENCY, cycle - e_cycle, e_name,
                                  test_errors);
                    compare_field("result", e_result, result, e_name, test_errors);
                    compare_field("inf", {31'd0, e_inf}, {31'd0, inf}, e_name, test_errors);
                    compare_field("zero", {31'd0, e_zero}, {31'd0, zero}, e_name,
                                  test_errors);
                    if (test_errors == 0)
                    begin
                        $display("test %0s: ok", e_name);
                        passed = passed + 1;
                    end
                    else
                    begin
                        $display("test %0s: %0d mismatches", e_name, test_errors);
                        failed = failed + 1;
                        errors = errors + test_errors;
                    end
                end
            end
            else if (done !== 1'b0)
            begin
                $display("At %0t, done is unknown", $time);
                errors = errors + 1;
            end

            if (start === 1'b1)   // Operation enters the pipeline at this edge
            begin
                q_result.push_back(exp_result);
                q_inf.push_back(exp_inf);
                q_zero.push_back(exp_zero);
                q_name.push_back(exp_name);
                q_cycle.push_back(cycle);
            end
        end
        pending = q_result.size();
    end

endmodule

`default_nettype wire

//--- posit_adder.sv
// Eight-stage pipelined posit32 adder, one operation per cycle
// Drive in1/in2 with a start strobe, the sum appears with done 8 cycles later
`timescale 1ns/1ps
`default_nettype none

module posit_adder #(
    parameter int ES = posit_pkg::DEFAULT_ES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  posit_pkg::posit_t  in1,
    input  posit_pkg::posit_t  in2,
    output posit_pkg::posit_t  result,
    output logic               inf,
    output logic               zero,
    output logic               done
);

    import posit_pkg::*;

    // Input register
    logic   r0_valid;
    posit_t r0_in1, r0_in2;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r0_valid <= 1'b0;
        else
            r0_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        r0_in1 <= in1;
        r0_in2 <= in2;
    end

    mag_t   a_abs, b_abs;
    logic   a_sign, b_sign, a_zero, b_zero, a_nar, b_nar;
    scale_t a_scale, b_scale;
    frac_t  a_frac, b_frac;

    posit_extract #(.ES(ES)) a_extract (
        .in(r0_in1), .abs(a_abs), .sign(a_sign), .scale(a_scale),
        .fraction(a_frac), .zero(a_zero), .nar(a_nar)
    );

    posit_extract #(.ES(ES)) b_extract (
        .in(r0_in2), .abs(b_abs), .sign(b_sign), .scale(b_scale),
        .fraction(b_frac), .zero(b_zero), .nar(b_nar)
    );

    logic a_ge_b;
    assign a_ge_b = (a_abs >= b_abs);   // Larger magnitude becomes hi

    // Align/add register
    logic   r1_valid;
    logic   r1_add, r1_sign, r1_nar, r1_hi_zero, r1_lo_zero;
    scale_t r1_hi_scale, r1_lo_scale;
    frac_t  r1_hi_frac, r1_lo_frac;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r1_valid <= 1'b0;
        else
            r1_valid <= r0_valid;
    end

    always_ff @(posedge clk)
    begin
        r1_add      <= a_sign ~^ b_sign;       // Equal signs add magnitudes
        r1_sign     <= a_ge_b ? a_sign : b_sign;
        r1_nar      <= a_nar | b_nar;
        r1_hi_zero  <= a_ge_b ? a_zero : b_zero;
        r1_lo_zero  <= a_ge_b ? b_zero : a_zero;
        r1_hi_scale <= a_ge_b ? a_scale : b_scale;
        r1_lo_scale <= a_ge_b ? b_scale : a_scale;
        r1_hi_frac  <= a_ge_b ? a_frac : b_frac;
        r1_lo_frac  <= a_ge_b ? b_frac : a_frac;
    end

    logic [7:0]         r1_scale_diff;
    logic [ABITS-1:0]   r1_hi_op, r1_lo_op, r1_lo_aligned;
    logic [2*ABITS-1:0] r1_lo_wide;
    logic               r1_lost;
    sum_t               r1_sum;

    assign r1_scale_diff = 8'(r1_hi_scale - r1_lo_scale);

    // Hidden bit, fraction, two guard bits
    assign r1_hi_op = {~r1_hi_zero, r1_hi_frac, 2'b00};
    assign r1_lo_op = {~r1_lo_zero, r1_lo_frac, 2'b00};

    assign r1_lo_wide    = {r1_lo_op, {ABITS{1'b0}}} >> r1_scale_diff;
    assign r1_lost       = (|r1_lo_wide[ABITS-1:0]) | ((r1_scale_diff >= 8'(2 * ABITS)) & (|r1_lo_op));
    assign r1_lo_aligned = r1_lo_wide[2*ABITS-1:ABITS] | {{ABITS-1{1'b0}}, r1_lost};  // Jam lost bits

    assign r1_sum = r1_add ? ({1'b0, r1_hi_op} + {1'b0, r1_lo_aligned})
                           : ({1'b0, r1_hi_op} - {1'b0, r1_lo_aligned});

    // Normalize-count register
    logic   r1b_valid;
    logic   r1b_sign, r1b_nar, r1b_zero, r1b_trunc;
    scale_t r1b_scale;
    sum_t   r1b_sum;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r1b_valid <= 1'b0;
        else
            r1b_valid <= r1_valid;
    end

    always_ff @(posedge clk)
    begin
        r1b_sign  <= r1_sign;
        r1b_nar   <= r1_nar;
        r1b_zero  <= r1_hi_zero & r1_lo_zero;
        r1b_trunc <= r1_lost;
        r1b_scale <= r1_hi_scale;
        r1b_sum   <= r1_sum;
    end

    lod_pos_t r1b_pos;

    leading_one_detect hidden_bit_lod (
        .in(r1b_sum),
        .pos(r1b_pos)
    );

    // Normalize-shift register
    logic     r2_valid;
    logic     r2_sign, r2_nar, r2_zero, r2_trunc, r2_rounded_zero;
    scale_t   r2_scale;
    sum_t     r2_sum, r2_frac_norm;
    lod_pos_t r2_pos;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r2_valid <= 1'b0;
        else
            r2_valid <= r1b_valid;
    end

    always_ff @(posedge clk)
    begin
        r2_sign  <= r1b_sign;
        r2_nar   <= r1b_nar;
        r2_zero  <= r1b_zero;
        r2_trunc <= r1b_trunc;
        r2_scale <= r1b_scale + 8'sd1 - scale_t'({3'b000, r1b_pos});  // Carry lifts scale by one
        r2_rounded_zero <= (r1b_pos == lod_pos_t'(31)) & ~r1b_sum[1];    // Cancelled sum
        r2_sum   <= r1b_sum;
        r2_pos   <= r1b_pos;
    end

    // Leading one shifted out, fraction left justified
    assign r2_frac_norm = (r2_sum << r2_pos) << 1;

    posit_round_pack #(.ES(ES)) round_pack (
        .clk(clk),
        .rst_n(rst_n),
        .valid_in(r2_valid),
        .sign(r2_sign),
        .scale(r2_scale),
        .zero_in(r2_zero),
        .nar_in(r2_nar),
        .rounded_zero(r2_rounded_zero),
        .truncated(r2_trunc),
        .fraction_norm(r2_frac_norm),
        .result(result),
        .inf(inf),
        .zero(zero),
        .done(done)
    );

endmodule

`default_nettype wire

//--- posit_extract.sv
// Combinational posit decoder: sign, scale, fraction and special flags
// Two instances sit behind the input register of the adder
`timescale 1ns/1ps
`default_nettype none

module posit_extract #(
    parameter int ES = posit_pkg::DEFAULT_ES
) (
    input  posit_pkg::posit_t  in,
    output posit_pkg::mag_t    abs,
    output logic               sign,
    output posit_pkg::scale_t  scale,
    output posit_pkg::frac_t   fraction,
    output logic               zero,
    output logic               nar
);

    import posit_pkg::*;

    assign sign = in[NBITS-1];
    assign zero = (in == '0);
    assign nar  = (in == {1'b1, {NBITS-1{1'b0}}}); // Lone sign bit

    // Negative words are decoded from their two's complement
    assign abs = in[NBITS-1] ? mag_t'(-in) : in[NBITS-2:0];

    always_comb
    begin : decode
        logic [5:0] run;
        logic       stop;
        mag_t       rem;
        mag_t       rem_es;
        int         regime;
        int         expo;

        // Length of the regime run, counted from the top magnitude bit
        run  = '0;
        stop = 1'b0;
        for (int i = NBITS - 2; i >= 0; i--)
        begin
            if (!stop)
            begin
                if (abs[i] == abs[NBITS-2])
                    run = run + 6'd1;
                else
                    stop = 1'b1;
            end
        end

        regime = abs[NBITS-2] ? int'(run) - 1 : -int'(run);

        // Drop regime run and its terminating bit
        rem = abs << (run + 6'd1);

        // Exponent sits at the top of what is left, ES of zero gives 0
        expo = int'(rem >> (NBITS - 1 - ES));

        rem_es   = rem << ES;
        fraction = rem_es[NBITS-2:2];    // Left justified fraction bits

        scale = scale_t'(regime * (1 << ES) + expo);
    end

endmodule

`default_nettype wire

//--- posit_pkg.sv
// Shared widths and types for the posit32 adder pipeline
// Imported by every RTL module of the adder
`default_nettype none

package posit_pkg;

    // Posit word width, fixed for this design
    localparam int NBITS = 32;

    // Aligned fraction datapath: fraction bits plus guard bits
    localparam int ABITS = NBITS - 3 + 3;

    // Exponent field size used unless the top level is told otherwise
    localparam int DEFAULT_ES = 2;

    // One posit word
    typedef logic [NBITS-1:0] posit_t;

    // Posit magnitude with the sign bit removed
    typedef logic [NBITS-2:0] mag_t;

    // Regime times 2^ES plus exponent
    typedef logic signed [7:0] scale_t;

    // Fraction without hidden bit, left justified
    typedef logic [NBITS-4:0] frac_t;

    // Raw fraction sum, top bit is the carry
    typedef logic [ABITS:0] sum_t;

    // Leading-one distance or normalization shift
    typedef logic [4:0] lod_pos_t;

endpackage

`default_nettype wire

//--- posit_round_pack.sv
// Back half of the posit adder with sticky bits, regime packing, rounding
// and sign restore over four register stages from valid_in to done
`timescale 1ns/1ps
`default_nettype none

module posit_round_pack #(
    parameter int ES = posit_pkg::DEFAULT_ES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                sign,
    input  posit_pkg::scale_t   scale,
    input  logic                zero_in,
    input  logic                nar_in,
    input  logic                rounded_zero,
    input  logic                truncated,
    input  posit_pkg::sum_t     fraction_norm,
    output posit_pkg::posit_t   result,
    output logic                inf,
    output logic                zero,
    output logic                done
);

    import posit_pkg::*;

    // Regime split and shift amounts
    scale_t     regime;
    logic       neg_regime;
    logic [6:0] regime_shift;
    logic [6:0] leftover_shift;
    logic [2:0] exponent;
    int         kept_frac;

    assign neg_regime = scale[7];
    assign regime     = scale >>> ES;
    assign exponent   = 3'(scale & ((1 << ES) - 1));
    assign regime_shift = neg_regime ? 7'(-regime) : 7'(regime + 1);

    // Fraction bits that still fit after sign, regime and exponent
    assign kept_frac      = NBITS - 2 - ES - int'(regime_shift);
    assign leftover_shift = (kept_frac < 0) ? 7'd0 : 7'(kept_frac);

    // Sticky stage
    logic       s1_valid;
    logic       s1_sign, s1_zero, s1_nar, s1_trunc, s1_neg;
    sum_t       s1_frac;
    logic [2:0] s1_exp;
    logic [6:0] s1_rshift, s1_lshift;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        s1_sign   <= sign;
        s1_zero   <= zero_in | rounded_zero;
        s1_nar    <= nar_in;
        s1_trunc  <= truncated;
        s1_neg    <= neg_regime;
        s1_frac   <= fraction_norm;
        s1_exp    <= exponent;
        s1_rshift <= regime_shift;
        s1_lshift <= leftover_shift;
    end

    sum_t                 s1_leftover;
    logic                 s1_bafter, s1_sticky;
    logic [2*NBITS-1:0]   s1_word;

    assign s1_leftover = s1_frac << s1_lshift;   // First dropped bit moves to the top
    assign s1_bafter   = s1_leftover[ABITS];
    assign s1_sticky   = s1_trunc | (|s1_leftover[ABITS-1:0]);

    // Regime run, terminator, exponent and fraction before the regime shift
    assign s1_word = {{NBITS{~s1_neg}}, s1_neg, {NBITS-1{1'b0}}}
                   | ({{2*NBITS-3{1'b0}}, s1_exp} << (NBITS - 1 - ES))
                   | ({s1_frac, {NBITS-1{1'b0}}} >> (ABITS + 1 + ES));

    // Regime shift stage
    logic               s2_valid;
    logic               s2_sign, s2_zero, s2_nar, s2_bafter, s2_sticky;
    logic [2*NBITS-1:0] s2_word;
    logic [6:0]         s2_rshift;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s2_valid <= 1'b0;
        else
            s2_valid <= s1_valid;
    end

    always_ff @(posedge clk)
    begin
        s2_sign   <= s1_sign;
        s2_zero   <= s1_zero;
        s2_nar    <= s1_nar;
        s2_bafter <= s1_bafter;
        s2_sticky <= s1_sticky;
        s2_word   <= s1_word;
        s2_rshift <= s1_rshift;
    end

    logic [2*NBITS-1:0] s2_shifted;
    assign s2_shifted = s2_word >> s2_rshift;

    // Round stage
    logic s3_valid;
    logic s3_sign, s3_zero, s3_nar, s3_bafter, s3_sticky;
    mag_t s3_mag;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s3_valid <= 1'b0;
        else
            s3_valid <= s2_valid;
    end

    always_ff @(posedge clk)
    begin
        s3_sign   <= s2_sign;
        s3_zero   <= s2_zero;
        s3_nar    <= s2_nar;
        s3_bafter <= s2_bafter;
        s3_sticky <= s2_sticky;
        s3_mag    <= s2_shifted[NBITS-1:1];   // Unsigned regime, exponent, fraction
    end

    logic s3_round_up;
    mag_t s3_rounded, s3_signed;

    // Round to nearest with ties to the even neighbour
    assign s3_round_up = s3_bafter & (s3_sticky | s3_mag[0]);
    assign s3_rounded  = s3_mag + mag_t'(s3_round_up);
    assign s3_signed   = s3_sign ? -s3_rounded : s3_rounded;

    // Output stage
    logic s4_valid;
    logic s4_sign, s4_zero, s4_nar;
    mag_t s4_mag;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s4_valid <= 1'b0;
        else
            s4_valid <= s3_valid;
    end

    always_ff @(posedge clk)
    begin
        s4_sign <= s3_sign;
        s4_zero <= s3_zero;
        s4_nar  <= s3_nar;
        s4_mag  <= s3_signed;
    end

    assign result = s4_nar  ? {1'b1, {NBITS-1{1'b0}}} :
                    s4_zero ? '0 : {s4_sign, s4_mag};
    assign inf  = s4_nar;
    assign zero = ~s4_nar & s4_zero;
    assign done = s4_valid;

endmodule

`default_nettype wire

//--- src.f
posit_pkg.sv
posit_extract.sv
leading_one_detect.sv
posit_round_pack.sv
posit_adder.sv
posit_add_checker.sv
tb_posit_adder.sv

//--- tb_posit_adder.sv
// Testbench top for the posit32 adder with ES of 2
// Sends a table of sums back to back, then again with random gaps
`timescale 1ns/1ps
`default_nettype none

module tb_posit_adder;

    import posit_pkg::*;

    localparam int          TEST_ES       = 2;
    localparam int          HALF_PERIOD   = 2;     // 4 ns clock
    localparam int          RESET_CYCLES  = 10;
    localparam int          LATENCY       = 8;
    localparam int          MARGIN_CYCLES = 64;
    localparam int          MAX_GAP       = 4;
    localparam int          MAX_TESTS     = 32;
    localparam logic [31:0] RANDOM_SEED   = 32'h4bed_4fc1;

    logic         clk;
    logic         rst_n;
    logic         start;
    posit_t       in1, in2, result;
    logic         inf, zero, done;
    posit_t       exp_result;
    logic         exp_inf, exp_zero;
    logic [159:0] exp_name;
    int           pending, passed, failed, errors;

    // Stimulus table
    posit_t       tab_in1[MAX_TESTS];
    posit_t       tab_in2[MAX_TESTS];
    posit_t       tab_result[MAX_TESTS];
    logic         tab_inf[MAX_TESTS];
    logic         tab_zero[MAX_TESTS];
    logic [159:0] tab_name[MAX_TESTS];
    int           gaps[MAX_TESTS];
    int           num_tests;
    int           limit_cycles;

    posit_adder #(.ES(TEST_ES)) posit_adder_i (
        .clk(clk), .rst_n(rst_n), .start(start), .in1(in1), .in2(in2),
        .result(result), .inf(inf), .zero(zero), .done(done)
    );

    posit_add_checker checker_i (
        .clk(clk), .rst_n(rst_n), .start(start),
        .exp_result(exp_result), .exp_inf(exp_inf), .exp_zero(exp_zero),
        .exp_name(exp_name), .result(result), .inf(inf), .zero(zero), .done(done),
        .pending(pending), .passed(passed), .failed(failed), .errors(errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task add_entry(input posit_t a, input posit_t b, input posit_t sum,
                   input logic is_nar, input logic is_zero, input logic [159:0] name);
        tab_in1[num_tests]    = a;
        tab_in2[num_tests]    = b;
        tab_result[num_tests] = sum;
        tab_inf[num_tests]    = is_nar;
        tab_zero[num_tests]   = is_zero;
        tab_name[num_tests]   = name;
        num_tests = num_tests + 1;
    endtask

    // Posit32 ES 2 sums with value 16^k * 2^e * (1 + f)
    task fill_table;
        add_entry(32'h4000_0000, 32'h4000_0000, 32'h4800_0000, 0, 0, "one_plus_one");
        add_entry(32'h4800_0000, 32'h4800_0000, 32'h5000_0000, 0, 0, "two_plus_two");
        add_entry(32'h4400_0000, 32'h4800_0000, 32'h4E00_0000, 0, 0, "p1_5_plus_2");
        add_entry(32'h5200_0000, 32'h4C00_0000, 32'h5800_0000, 0, 0, "p5_plus_3");
        add_entry(32'h3800_0000, 32'h4400_0000, 32'h4800_0000, 0, 0, "half_plus_1_5");
        add_entry(32'hC000_0000, 32'hC000_0000, 32'hB800_0000, 0, 0, "neg1_plus_neg1");
        add_entry(32'h4C00_0000, 32'hC000_0000, 32'h4800_0000, 0, 0, "p3_minus_1");
        add_entry(32'h4000_0000, 32'hBC00_0000, 32'hC800_0000, 0, 0, "p1_minus_1_5");
        add_entry(32'h4C00_0000, 32'hB400_0000, 32'h0000_0000, 0, 1, "p3_minus_3");
        add_entry(32'hB800_0000, 32'h4800_0000, 32'h0000_0000, 0, 1, "neg2_plus_2");
        add_entry(32'h0000_0000, 32'h4400_0000, 32'h4400_0000, 0, 0, "zero_plus_1_5");
        add_entry(32'h4E00_0000, 32'h0000_0000, 32'h4E00_0000, 0, 0, "p3_5_plus_zero");
        add_entry(32'hB400_0000, 32'h0000_0000, 32'hB400_0000, 0, 0, "neg3_plus_zero");
        add_entry(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 0, 1, "zero_plus_zero");
        add_entry(32'h8000_0000, 32'h4000_0000, 32'h8000_0000, 1, 0, "nar_plus_one");
        add_entry(32'h4800_0000, 32'h8000_0000, 32'h8000_0000, 1, 0, "two_plus_nar");
        add_entry(32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1, 0, "zero_plus_nar");
        // 2^-28 is half an ulp of 1.0
        add_entry(32'h4000_0000, 32'h0080_0000, 32'h4000_0000, 0, 0, "tie_down_even");
        add_entry(32'h4000_0001, 32'h0080_0000, 32'h4000_0002, 0, 0, "tie_up_even");
        add_entry(32'h4000_0000, 32'h0088_0000, 32'h4000_0001, 0, 0, "above_half");
        // 2^-40 only reaches the sticky bit
        add_entry(32'h4000_0000, 32'h0010_0000, 32'h4000_0000, 0, 0, "gap_one");
        add_entry(32'h6000_0000, 32'h0010_0000, 32'h6000_0000, 0, 0, "gap_sixteen");
        add_entry(32'hB000_0000, 32'h0010_0000, 32'hB000_0000, 0, 0, "gap_neg_four");
    endtask

    task send_entry(input int idx);
        @(negedge clk);
        in1        = tab_in1[idx];
        in2        = tab_in2[idx];
        exp_result = tab_result[idx];
        exp_inf    = tab_inf[idx];
        exp_zero   = tab_zero[idx];
        exp_name   = tab_name[idx];
        start      = 1'b1;
    endtask

    task idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    initial
    begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, results still outstanding: %0d",
                 limit_cycles, pending);
        $display("Checks failed");
        $finish;
    end

    initial
    begin : main_sequence
        int seed_state;
        int gap_sum;

        rst_n        = 1'b0;
        start        = 1'b0;
        in1          = '0;
        in2          = '0;
        exp_result   = '0;
        exp_inf      = 1'b0;
        exp_zero     = 1'b0;
        exp_name     = '0;
        num_tests    = 0;
        limit_cycles = 0;
        fill_table();

        seed_state = $urandom(RANDOM_SEED);
        gap_sum    = 0;
        for (int i = 0; i < num_tests; i++)
        begin
            gaps[i] = $urandom % (MAX_GAP + 1);
            gap_sum = gap_sum + gaps[i];
        end
        limit_cycles = RESET_CYCLES + 2 * num_tests + gap_sum + LATENCY + MARGIN_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(2);    // Checker sees done stay low after reset

        for (int i = 0; i < num_tests; i++)    // Back to back
            send_entry(i);
        idle_cycles(1);

        for (int i = 0; i < num_tests; i++)
        begin
            send_entry(i);
            idle_cycles(gaps[i]);
        end
        idle_cycles(1);

        idle_cycles(LATENCY + 4);    // Last result plus room for a stray done
        checker_i.report_leftovers();

        $display("Summary: %0d tests ok, %0d tests with mismatches, %0d errors in total",
                 passed, failed, errors);
        if (errors == 0 && passed == 2 * num_tests)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
